/* Makefile */
SIM   ?= verilator
TOP   ?= tb_lsu_ctrl
LOG   ?= sim.log
FLIST ?= list.f
OBJ   ?= obj_dir

.PHONY: sim clean

sim:
	$(SIM) --binary --timing --assert --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

/* list.f */
lsu_pkg.sv
lsu_outs_fifo.sv
lsu_cmd_router.sv
lsu_rsp_wbck.sv
lsu_ctrl.sv
lsu_ctrl_checker.sv
tb_lsu_ctrl.sv

/* lsu_cmd_router.sv */
////////////////////////////////////////////////////////////////////////////
// LSU command router
// Region decode, issue control and exclusive monitor for DTCM and BIU
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module lsu_cmd_router
  import lsu_pkg::*;
#(
  parameter int unsigned DTCM_ADDR_W = 16
) (
  input  wire                     clk,
  input  wire                     i_arst_n,
  input  wire                     i_commit_trap,
  input  wire                     i_commit_mret,
  input  wire lsu_addr_t          i_dtcm_region_indic,
  // AGU command
  input  wire                     i_agu_cmd_valid,
  output logic                    o_agu_cmd_ready,
  input  wire lsu_addr_t          i_agu_cmd_addr,
  input  wire                     i_agu_cmd_read,
  input  wire lsu_data_t          i_agu_cmd_wdata,
  input  wire lsu_mask_t          i_agu_cmd_wmask,
  input  wire                     i_agu_cmd_lock,
  input  wire                     i_agu_cmd_excl,
  input  wire lsu_size_t          i_agu_cmd_size,
  input  wire                     i_agu_cmd_back2agu,
  input  wire                     i_agu_cmd_usign,
  input  wire lsu_itag_t          i_agu_cmd_itag,
  // DTCM command
  output logic                    o_dtcm_cmd_valid,
  input  wire                     i_dtcm_cmd_ready,
  output logic [DTCM_ADDR_W-1:0]  o_dtcm_cmd_addr,
  output logic                    o_dtcm_cmd_read,
  output lsu_data_t               o_dtcm_cmd_wdata,
  output lsu_mask_t               o_dtcm_cmd_wmask,
  output logic                    o_dtcm_cmd_lock,
  output logic                    o_dtcm_cmd_excl,
  output lsu_size_t               o_dtcm_cmd_size,
  // BIU command
  output logic                    o_biu_cmd_valid,
  input  wire                     i_biu_cmd_ready,
  output lsu_addr_t               o_biu_cmd_addr,
  output logic                    o_biu_cmd_read,
  output lsu_data_t               o_biu_cmd_wdata,
  output lsu_mask_t               o_biu_cmd_wmask,
  output logic                    o_biu_cmd_lock,
  output logic                    o_biu_cmd_excl,
  output lsu_size_t               o_biu_cmd_size,
  // Outstanding FIFO
  output logic                    o_push,
  output logic [OUTS_ENTRY_W-1:0] o_entry,
  input  wire                     i_full,
  input  wire                     i_head_valid,
  input  wire                     i_head_dtcm
);

  logic      cmd_dtcm;
  logic      diff_target;
  logic      issue_ok;
  logic      all_ready;
  logic      cmd_fire;
  logic      excl_flg_q;
  lsu_addr_t excl_addr_q;
  logic      addr_eq_excl;
  logic      excl_set;
  logic      excl_clr;
  logic      scond;
  logic      scond_true;
  lsu_mask_t wmask_pos;

  //////////////////////////////////////////////////////////////////////////
  // Region decode and issue condition

  assign cmd_dtcm = (i_agu_cmd_addr[ADDR_W-1:DTCM_ADDR_W]
                     == i_dtcm_region_indic[ADDR_W-1:DTCM_ADDR_W]);

  // Outstanding work to the other target must drain first
  assign diff_target = i_head_valid & (i_head_dtcm != cmd_dtcm);
  assign issue_ok    = ~i_full & ~diff_target;

  // Ready asks for every target, which keeps the address out of the ready path
  assign all_ready       = i_dtcm_cmd_ready & i_biu_cmd_ready;
  assign o_agu_cmd_ready = issue_ok & all_ready;
  assign cmd_fire        = i_agu_cmd_valid & o_agu_cmd_ready;

  assign o_dtcm_cmd_valid = i_agu_cmd_valid & issue_ok & cmd_dtcm & i_biu_cmd_ready;
  assign o_biu_cmd_valid  = i_agu_cmd_valid & issue_ok & ~cmd_dtcm & i_dtcm_cmd_ready;

  //////////////////////////////////////////////////////////////////////////
  // Exclusive reservation

  assign addr_eq_excl = (i_agu_cmd_addr == excl_addr_q);
  assign excl_set     = cmd_fire & i_agu_cmd_read & i_agu_cmd_excl;
  // Any store to the reserved address kills it, as does a trap or mret
  assign excl_clr     = (cmd_fire & ~i_agu_cmd_read & addr_eq_excl & excl_flg_q)
                      | i_commit_trap | i_commit_mret;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      excl_flg_q <= 1'b0;
    end else if (excl_set | excl_clr) begin
      excl_flg_q <= excl_set | ~excl_clr;
    end
  end

  always_ff @(posedge clk) begin
    if (excl_set) begin
      excl_addr_q <= i_agu_cmd_addr;
    end
  end

  assign scond      = i_agu_cmd_excl & ~i_agu_cmd_read;
  assign scond_true = scond & addr_eq_excl & excl_flg_q;
  // Failing store-conditional goes out with no byte enabled
  assign wmask_pos  = (scond & ~scond_true) ? '0 : i_agu_cmd_wmask;

  //////////////////////////////////////////////////////////////////////////
  // Target payloads and FIFO entry

  assign o_dtcm_cmd_addr  = i_agu_cmd_addr[DTCM_ADDR_W-1:0];
  assign o_dtcm_cmd_read  = i_agu_cmd_read;
  assign o_dtcm_cmd_wdata = i_agu_cmd_wdata;
  assign o_dtcm_cmd_wmask = wmask_pos;
  assign o_dtcm_cmd_lock  = i_agu_cmd_lock;
  assign o_dtcm_cmd_excl  = i_agu_cmd_excl;
  assign o_dtcm_cmd_size  = i_agu_cmd_size;

  assign o_biu_cmd_addr  = i_agu_cmd_addr;
  assign o_biu_cmd_read  = i_agu_cmd_read;
  assign o_biu_cmd_wdata = i_agu_cmd_wdata;
  assign o_biu_cmd_wmask = wmask_pos;
  assign o_biu_cmd_lock  = i_agu_cmd_lock;
  assign o_biu_cmd_excl  = i_agu_cmd_excl;
  assign o_biu_cmd_size  = i_agu_cmd_size;

  assign o_push  = cmd_fire;
  assign o_entry = {cmd_dtcm, scond_true, i_agu_cmd_back2agu, i_agu_cmd_usign,
                    i_agu_cmd_read, i_agu_cmd_excl, i_agu_cmd_size, i_agu_cmd_itag,
                    i_agu_cmd_addr};

endmodule

`default_nettype wire

/* lsu_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// LSU control top level
// Routes AGU commands to DTCM or BIU and returns responses in order
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module lsu_ctrl
  import lsu_pkg::*;
#(
  parameter int unsigned OUTS_NUM    = 2,
  parameter int unsigned DTCM_ADDR_W = 16
) (
  input  wire                    clk,
  input  wire                    i_arst_n,
  input  wire                    i_commit_trap,
  input  wire                    i_commit_mret,
  input  wire lsu_addr_t         i_dtcm_region_indic,
  output logic                   o_lsu_ctrl_active,
  // AGU command and response
  input  wire                    i_agu_cmd_valid,
  output logic                   o_agu_cmd_ready,
  input  wire lsu_addr_t         i_agu_cmd_addr,
  input  wire                    i_agu_cmd_read,
  input  wire lsu_data_t         i_agu_cmd_wdata,
  input  wire lsu_mask_t         i_agu_cmd_wmask,
  input  wire                    i_agu_cmd_lock,
  input  wire                    i_agu_cmd_excl,
  input  wire lsu_size_t         i_agu_cmd_size,
  input  wire                    i_agu_cmd_back2agu,
  input  wire                    i_agu_cmd_usign,
  input  wire lsu_itag_t         i_agu_cmd_itag,
  output logic                   o_agu_rsp_valid,
  input  wire                    i_agu_rsp_ready,
  output logic                   o_agu_rsp_err,
  output logic                   o_agu_rsp_excl_ok,
  output lsu_data_t              o_agu_rsp_rdata,
  // Write-back
  output logic                   o_lsu_o_valid,
  input  wire                    i_lsu_o_ready,
  output lsu_data_t              o_lsu_o_wbck_wdat,
  output lsu_itag_t              o_lsu_o_wbck_itag,
  output logic                   o_lsu_o_wbck_err,
  output logic                   o_lsu_o_cmt_buserr,
  output lsu_addr_t              o_lsu_o_cmt_badaddr,
  output logic                   o_lsu_o_cmt_ld,
  output logic                   o_lsu_o_cmt_st,
  // DTCM
  output logic                   o_dtcm_cmd_valid,
  input  wire                    i_dtcm_cmd_ready,
  output logic [DTCM_ADDR_W-1:0] o_dtcm_cmd_addr,
  output logic                   o_dtcm_cmd_read,
  output lsu_data_t              o_dtcm_cmd_wdata,
  output lsu_mask_t              o_dtcm_cmd_wmask,
  output logic                   o_dtcm_cmd_lock,
  output logic                   o_dtcm_cmd_excl,
  output lsu_size_t              o_dtcm_cmd_size,
  input  wire                    i_dtcm_rsp_valid,
  output logic                   o_dtcm_rsp_ready,
  input  wire                    i_dtcm_rsp_err,
  input  wire                    i_dtcm_rsp_excl_ok,
  input  wire lsu_data_t         i_dtcm_rsp_rdata,
  // BIU
  output logic                   o_biu_cmd_valid,
  input  wire                    i_biu_cmd_ready,
  output lsu_addr_t              o_biu_cmd_addr,
  output logic                   o_biu_cmd_read,
  output lsu_data_t              o_biu_cmd_wdata,
  output lsu_mask_t              o_biu_cmd_wmask,
  output logic                   o_biu_cmd_lock,
  output logic                   o_biu_cmd_excl,
  output lsu_size_t              o_biu_cmd_size,
  input  wire                    i_biu_rsp_valid,
  output logic                   o_biu_rsp_ready,
  input  wire                    i_biu_rsp_err,
  input  wire                    i_biu_rsp_excl_ok,
  input  wire lsu_data_t         i_biu_rsp_rdata
);

  logic                    push;
  logic                    pop;
  logic                    full;
  logic                    head_valid;
  logic                    head_dtcm;
  logic [OUTS_ENTRY_W-1:0] entry;
  logic [OUTS_ENTRY_W-1:0] head_entry;

  // Outside ports connect by name, FIFO links are listed
  lsu_cmd_router #(
    .DTCM_ADDR_W (DTCM_ADDR_W)
  ) u_cmd_router (
    .o_push       (push),
    .o_entry      (entry),
    .i_full       (full),
    .i_head_valid (head_valid),
    .i_head_dtcm  (head_dtcm),
    .*
  );

  lsu_outs_fifo #(
    .OUTS_NUM (OUTS_NUM)
  ) u_outs_fifo (
    .i_push       (push),
    .i_entry      (entry),
    .i_pop        (pop),
    .o_full       (full),
    .o_head_valid (head_valid),
    .o_head_dtcm  (head_dtcm),
    .o_head_entry (head_entry),
    .*
  );

  lsu_rsp_wbck u_rsp_wbck (
    .i_head_valid (head_valid),
    .i_head_entry (head_entry),
    .o_pop        (pop),
    .*
  );

  // Busy while a command waits or anything is still outstanding
  assign o_lsu_ctrl_active = i_agu_cmd_valid | head_valid;

endmodule

`default_nettype wire

/* lsu_ctrl_checker.sv */
////////////////////////////////////////////////////////////////////////////
// LSU control handshake assertions, bound into the top level
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module lsu_ctrl_checker (
  input wire clk,
  input wire i_arst_n,
  input wire o_dtcm_cmd_valid,
  input wire i_dtcm_cmd_ready,
  input wire o_biu_cmd_valid,
  input wire i_biu_cmd_ready,
  input wire o_lsu_o_valid,
  input wire o_agu_rsp_valid,
  input wire o_lsu_ctrl_active
);

  // A target command only goes out while the other target is ready
  a_dtcm_neighbour: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_dtcm_cmd_valid |-> i_biu_cmd_ready) else $error("DTCM valid while BIU not ready");

  a_biu_neighbour: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_biu_cmd_valid |-> i_dtcm_cmd_ready) else $error("BIU valid while DTCM not ready");

  a_one_target: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(o_dtcm_cmd_valid && o_biu_cmd_valid)) else $error("Both target commands valid");

  a_one_rsp: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(o_lsu_o_valid && o_agu_rsp_valid)) else $error("Write-back and AGU response together");

  a_idle_reset: assert property (@(posedge clk)
    $rose(i_arst_n) |-> !o_lsu_ctrl_active) else $error("Active right after reset");

endmodule

bind lsu_ctrl lsu_ctrl_checker u_checker (
  .clk               (clk),
  .i_arst_n          (i_arst_n),
  .o_dtcm_cmd_valid  (o_dtcm_cmd_valid),
  .i_dtcm_cmd_ready  (i_dtcm_cmd_ready),
  .o_biu_cmd_valid   (o_biu_cmd_valid),
  .i_biu_cmd_ready   (i_biu_cmd_ready),
  .o_lsu_o_valid     (o_lsu_o_valid),
  .o_agu_rsp_valid   (o_agu_rsp_valid),
  .o_lsu_ctrl_active (o_lsu_ctrl_active)
);

`default_nettype wire

/* lsu_ctrl_patterns.txt */
// First word: number of commands. Then one command per line:
// read size usign excl back2agu itag addr wdata rsp_rdata err target(1=DTCM) wb wmask_zero trap
17
1 2 0 0 0 0 80000010 00000000 11223344 0 1 11223344 0 0
1 0 0 0 0 1 20000001 00000000 00008000 0 0 ffffff80 0 0
1 0 1 0 0 2 80000023 00000000 a5000000 0 1 000000a5 0 0
1 1 0 0 0 3 20000002 00000000 9abc0000 0 0 ffff9abc 0 0
1 1 1 0 0 0 80000022 00000000 9abc1234 0 1 00009abc 0 0
1 1 0 0 0 1 80000030 00000000 00007fff 0 1 00007fff 0 0
0 2 0 0 0 2 20000040 deadbeef 00000000 0 0 00000000 0 0
1 2 0 0 1 3 80000100 00000000 cafef00d 0 1 cafef00d 0 0
1 2 0 0 1 0 20000100 00000000 12345678 0 0 12345678 0 0
1 2 0 0 0 1 80000200 00000000 00000000 1 1 00000000 0 0
0 2 0 0 0 2 20000300 00000055 00000000 1 0 00000000 0 0
1 2 0 1 0 3 80000400 00000000 55aa55aa 0 1 55aa55aa 0 0
0 2 0 1 0 0 80000400 00000077 00000000 0 1 00000000 0 0
0 2 0 1 0 1 80000400 00000078 00000000 0 1 00000001 1 0
1 2 0 1 0 2 20000500 00000000 0f0f0f0f 0 0 0f0f0f0f 0 0
0 2 0 1 0 3 20000500 00000099 00000000 0 0 00000001 1 1
1 2 0 1 0 0 80000600 00000000 01020304 0 1 01020304 0 0
0 2 0 1 0 1 80000604 00000011 00000000 0 1 00000001 1 0
0 2 0 1 0 2 80000600 00000022 00000000 0 1 00000000 0 0
1 2 0 0 0 3 20000010 00000000 01020304 0 0 01020304 0 0
1 2 0 0 0 0 80000020 00000000 0a0b0c0d 0 1 0a0b0c0d 0 0
1 0 1 0 0 1 20000020 00000000 000000ff 0 0 000000ff 0 0
1 1 1 0 0 2 80000042 00000000 beef0000 0 1 0000beef 0 0

/* lsu_outs_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Outstanding command FIFO
// Keeps the side information of issued commands in issue order
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module lsu_outs_fifo
  import lsu_pkg::*;
#(
  parameter int unsigned OUTS_NUM = 2
) (
  input  wire                     clk,
  input  wire                     i_arst_n,
  input  wire                     i_push,
  input  wire [OUTS_ENTRY_W-1:0]  i_entry,
  input  wire                     i_pop,
  output logic                    o_full,
  output logic                    o_head_valid,
  output logic                    o_head_dtcm,
  output logic [OUTS_ENTRY_W-1:0] o_head_entry
);

  // Depth 1 still needs a one-bit pointer
  localparam int unsigned PTR_W = (OUTS_NUM > 1) ? $clog2(OUTS_NUM) : 1;
  localparam int unsigned CNT_W = $clog2(OUTS_NUM + 1);

  logic [OUTS_ENTRY_W-1:0] mem [OUTS_NUM];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        count;
  logic                    full;
  logic                    wen;
  logic                    ren;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(OUTS_NUM - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full         = (count == CNT_W'(OUTS_NUM));
  assign o_head_valid = (count != '0);

  // A pop frees the slot for a push in the same cycle
  assign wen    = i_push & (~full | i_pop);
  assign ren    = i_pop & o_head_valid;
  assign o_full = full & ~i_pop;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wen) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (ren) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (wen & ~ren) begin
        count <= count + 1'b1;
      end else if (ren & ~wen) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[wr_ptr] <= i_entry;
    end
  end

  // Head fields act as control, so they read zero when empty
  assign o_head_entry = o_head_valid ? mem[rd_ptr] : '0;
  assign o_head_dtcm  = o_head_entry[OUTS_DTCM_BIT];

endmodule

`default_nettype wire

/* lsu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// LSU control shared definitions
// Data, address and tag widths, access sizes and the outstanding entry
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package lsu_pkg;

  localparam int unsigned XLEN   = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned ITAG_W = 2;

  typedef logic [XLEN-1:0]   lsu_data_t;
  typedef logic [ADDR_W-1:0] lsu_addr_t;
  typedef logic [XLEN/8-1:0] lsu_mask_t;
  typedef logic [1:0]        lsu_size_t;
  typedef logic [ITAG_W-1:0] lsu_itag_t;

  // Access size encoding of the command size field
  localparam lsu_size_t SIZE_B = 2'd0;
  localparam lsu_size_t SIZE_H = 2'd1;
  localparam lsu_size_t SIZE_W = 2'd2;

  // Outstanding entry, MSB first:
  //   dtcm, scond_true, back2agu, usign, read, excl, size, itag, addr
  localparam int unsigned OUTS_ENTRY_W = 6 + $bits(lsu_size_t) + ITAG_W + ADDR_W;

  // Target flag sits on top of the entry
  localparam int unsigned OUTS_DTCM_BIT = OUTS_ENTRY_W - 1;

endpackage

`default_nettype wire

/* lsu_rsp_wbck.sv */
////////////////////////////////////////////////////////////////////////////
// LSU response and write-back
// Picks the in-order response, formats load data, splits AGU or write-back
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module lsu_rsp_wbck
  import lsu_pkg::*;
(
  // Outstanding FIFO head
  input  wire                    i_head_valid,
  input  wire [OUTS_ENTRY_W-1:0] i_head_entry,
  output logic                   o_pop,
  // DTCM response
  input  wire                    i_dtcm_rsp_valid,
  output logic                   o_dtcm_rsp_ready,
  input  wire                    i_dtcm_rsp_err,
  input  wire                    i_dtcm_rsp_excl_ok,
  input  wire lsu_data_t         i_dtcm_rsp_rdata,
  // BIU response
  input  wire                    i_biu_rsp_valid,
  output logic                   o_biu_rsp_ready,
  input  wire                    i_biu_rsp_err,
  input  wire                    i_biu_rsp_excl_ok,
  input  wire lsu_data_t         i_biu_rsp_rdata,
  // AGU response
  output logic                   o_agu_rsp_valid,
  input  wire                    i_agu_rsp_ready,
  output logic                   o_agu_rsp_err,
  output logic                   o_agu_rsp_excl_ok,
  output lsu_data_t              o_agu_rsp_rdata,
  // Write-back
  output logic                   o_lsu_o_valid,
  input  wire                    i_lsu_o_ready,
  output lsu_data_t              o_lsu_o_wbck_wdat,
  output lsu_itag_t              o_lsu_o_wbck_itag,
  output logic                   o_lsu_o_wbck_err,
  output logic                   o_lsu_o_cmt_buserr,
  output lsu_addr_t              o_lsu_o_cmt_badaddr,
  output logic                   o_lsu_o_cmt_ld,
  output logic                   o_lsu_o_cmt_st
);

  logic      head_dtcm;
  logic      head_biu;
  logic      scond_true;
  logic      back2agu;
  logic      usign;
  logic      read;
  logic      excl;
  lsu_size_t size;
  lsu_itag_t itag;
  lsu_addr_t addr;
  logic      rsp_valid;
  logic      rsp_ready;
  logic      rsp_err;
  lsu_data_t rsp_rdata;
  lsu_data_t rdata_algn;
  lsu_data_t ld_data;

  assign {head_dtcm, scond_true, back2agu, usign, read, excl, size, itag, addr} = i_head_entry;

  // Empty head decodes to zero, so BIU needs the valid as well
  assign head_biu = i_head_valid & ~head_dtcm;

  assign rsp_valid = (head_dtcm & i_dtcm_rsp_valid) | (head_biu & i_biu_rsp_valid);
  assign rsp_err   = head_dtcm ? i_dtcm_rsp_err : i_biu_rsp_err;
  assign rsp_rdata = head_dtcm ? i_dtcm_rsp_rdata : i_biu_rsp_rdata;

  assign rsp_ready        = back2agu ? i_agu_rsp_ready : i_lsu_o_ready;
  assign o_dtcm_rsp_ready = head_dtcm & rsp_ready;
  assign o_biu_rsp_ready  = head_biu & rsp_ready;
  assign o_pop            = rsp_valid & rsp_ready;

  // Back to the AGU untouched
  assign o_agu_rsp_valid   = rsp_valid & back2agu;
  assign o_agu_rsp_err     = rsp_err;
  assign o_agu_rsp_excl_ok = head_dtcm ? i_dtcm_rsp_excl_ok : i_biu_rsp_excl_ok;
  assign o_agu_rsp_rdata   = rsp_rdata;

  //////////////////////////////////////////////////////////////////////////
  // Load data alignment and extension

  assign rdata_algn = rsp_rdata >> {addr[1:0], 3'b000};

  always_comb begin
    case (size)
      SIZE_B:  ld_data = usign ? {{(XLEN-8){1'b0}}, rdata_algn[7:0]}
                               : {{(XLEN-8){rdata_algn[7]}}, rdata_algn[7:0]};
      SIZE_H:  ld_data = usign ? {{(XLEN-16){1'b0}}, rdata_algn[15:0]}
                               : {{(XLEN-16){rdata_algn[15]}}, rdata_algn[15:0]};
      SIZE_W:  ld_data = rdata_algn;
      default: ld_data = rdata_algn;
    endcase
  end

  // Store-conditional reports 0 on success and 1 on failure
  assign o_lsu_o_wbck_wdat = (excl & ~read) ? (scond_true ? '0 : lsu_data_t'(1)) : ld_data;

  assign o_lsu_o_valid       = rsp_valid & ~back2agu;
  assign o_lsu_o_wbck_itag   = itag;
  assign o_lsu_o_wbck_err    = rsp_err;
  assign o_lsu_o_cmt_buserr  = rsp_err;
  assign o_lsu_o_cmt_badaddr = addr;
  assign o_lsu_o_cmt_ld      = read;
  assign o_lsu_o_cmt_st      = ~read;

endmodule

`default_nettype wire

/* tb_lsu_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// LSU control testbench
// Pattern driven AGU commands, DTCM and BIU target models, in-order checks
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_lsu_ctrl
  import lsu_pkg::*;
;

  localparam int NCOL    = 14;
  localparam int MAXPAT  = 64;
  localparam int C_READ  = 0;
  localparam int C_SIZE  = 1;
  localparam int C_USIGN = 2;
  localparam int C_EXCL  = 3;
  localparam int C_B2A   = 4;
  localparam int C_ITAG  = 5;
  localparam int C_ADDR  = 6;
  localparam int C_WDATA = 7;
  localparam int C_RDATA = 8;
  localparam int C_ERR   = 9;
  localparam int C_TGT   = 10;
  localparam int C_WB    = 11;
  localparam int C_WMZ   = 12;
  localparam int C_TRAP  = 13;
  localparam int IDLE_LIMIT = 500;

  logic clk, i_arst_n, i_commit_trap, i_commit_mret, o_lsu_ctrl_active;
  lsu_addr_t i_dtcm_region_indic;
  logic i_agu_cmd_valid, o_agu_cmd_ready, i_agu_cmd_read, i_agu_cmd_lock, i_agu_cmd_excl;
  logic i_agu_cmd_back2agu, i_agu_cmd_usign;
  lsu_addr_t i_agu_cmd_addr;
  lsu_data_t i_agu_cmd_wdata;
  lsu_mask_t i_agu_cmd_wmask;
  lsu_size_t i_agu_cmd_size;
  lsu_itag_t i_agu_cmd_itag;
  logic o_agu_rsp_valid, i_agu_rsp_ready, o_agu_rsp_err, o_agu_rsp_excl_ok;
  lsu_data_t o_agu_rsp_rdata;
  logic o_lsu_o_valid, i_lsu_o_ready, o_lsu_o_wbck_err, o_lsu_o_cmt_buserr;
  logic o_lsu_o_cmt_ld, o_lsu_o_cmt_st;
  lsu_data_t o_lsu_o_wbck_wdat;
  lsu_itag_t o_lsu_o_wbck_itag;
  lsu_addr_t o_lsu_o_cmt_badaddr;
  // DTCM side
  logic o_dtcm_cmd_valid, i_dtcm_cmd_ready, o_dtcm_cmd_read, o_dtcm_cmd_lock, o_dtcm_cmd_excl;
  logic [15:0] o_dtcm_cmd_addr;
  lsu_data_t o_dtcm_cmd_wdata, i_dtcm_rsp_rdata;
  lsu_mask_t o_dtcm_cmd_wmask;
  lsu_size_t o_dtcm_cmd_size;
  logic i_dtcm_rsp_valid, o_dtcm_rsp_ready, i_dtcm_rsp_err, i_dtcm_rsp_excl_ok;
  // BIU side
  logic o_biu_cmd_valid, i_biu_cmd_ready, o_biu_cmd_read, o_biu_cmd_lock, o_biu_cmd_excl;
  lsu_addr_t o_biu_cmd_addr;
  lsu_data_t o_biu_cmd_wdata, i_biu_rsp_rdata;
  lsu_mask_t o_biu_cmd_wmask;
  lsu_size_t o_biu_cmd_size;
  logic i_biu_rsp_valid, o_biu_rsp_ready, i_biu_rsp_err, i_biu_rsp_excl_ok;

  logic [31:0] pat [0:NCOL*MAXPAT];
  logic [31:0] rnd_state;
  logic [31:0] w;
  logic [31:0] hold_data;
  int n_pat, issue_idx, done_cnt, idle, idx;
  int errors, checks, test_err;
  int dd, bd;
  int dq[$];
  int bq[$];
  logic dp, bp, trap_sent, hold_valid, timed_out, tgt;

  lsu_ctrl #(
    .OUTS_NUM    (2),
    .DTCM_ADDR_W (16)
  ) dut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] field(input int i, input int col);
    return pat[1 + i*NCOL + col];
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at time %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  function automatic int rand_delay();
    rnd_state = xorshift32(rnd_state);
    return int'(rnd_state[1:0]) + 1;
  endfunction

  // Command fields held until the DUT takes them
  task automatic drive_cmd(input int i);
    w = field(i, C_READ);
    i_agu_cmd_read = w[0];
    w = field(i, C_SIZE);
    i_agu_cmd_size = w[1:0];
    w = field(i, C_USIGN);
    i_agu_cmd_usign = w[0];
    w = field(i, C_EXCL);
    i_agu_cmd_excl = w[0];
    // Lock rides along with exclusive accesses
    i_agu_cmd_lock = w[0];
    w = field(i, C_B2A);
    i_agu_cmd_back2agu = w[0];
    w = field(i, C_ITAG);
    i_agu_cmd_itag = w[ITAG_W-1:0];
    i_agu_cmd_addr  = field(i, C_ADDR);
    i_agu_cmd_wdata = field(i, C_WDATA);
  endtask

  // Target models answer their queue front after a short random delay
  task automatic drive_targets();
    if (!dp && dq.size() > 0) begin
      if (dd > 1) dd--;
      else dp = 1'b1;
    end
    if (!bp && bq.size() > 0) begin
      if (bd > 1) bd--;
      else bp = 1'b1;
    end
    i_dtcm_rsp_valid = dp;
    i_dtcm_rsp_rdata = dp ? field(dq[0], C_RDATA) : '0;
    w = dp ? field(dq[0], C_ERR) : '0;
    i_dtcm_rsp_err = w[0];
    // Odd tests come back with excl_ok set
    i_dtcm_rsp_excl_ok = dp && (dq[0] % 2 == 1);
    i_biu_rsp_valid = bp;
    i_biu_rsp_rdata = bp ? field(bq[0], C_RDATA) : '0;
    w = bp ? field(bq[0], C_ERR) : '0;
    i_biu_rsp_err = w[0];
    i_biu_rsp_excl_ok = bp && (bq[0] % 2 == 1);
  endtask

  task automatic check_cmd();
    w   = field(issue_idx, C_TGT);
    tgt = w[0];
    check_val(32'(o_dtcm_cmd_valid), 32'(tgt), "DTCM command valid");
    check_val(32'(o_biu_cmd_valid), 32'(!tgt), "BIU command valid");
    w = field(issue_idx, C_ADDR);
    if (o_dtcm_cmd_valid) begin
      check_val({16'h0, o_dtcm_cmd_addr}, {16'h0, w[15:0]}, "DTCM address");
      check_val(32'(o_dtcm_cmd_wmask == '0), field(issue_idx, C_WMZ), "DTCM wmask zero");
      check_val(32'(o_dtcm_cmd_read), field(issue_idx, C_READ), "DTCM read");
      check_val(o_dtcm_cmd_wdata, field(issue_idx, C_WDATA), "DTCM write data");
      check_val(32'(o_dtcm_cmd_size), field(issue_idx, C_SIZE), "DTCM size");
      check_val(32'(o_dtcm_cmd_excl), field(issue_idx, C_EXCL), "DTCM exclusive");
      check_val(32'(o_dtcm_cmd_lock), field(issue_idx, C_EXCL), "DTCM lock");
      if (dq.size() == 0) dd = rand_delay();
      dq.push_back(issue_idx);
    end else begin
      check_val(o_biu_cmd_addr, w, "BIU address");
      check_val(32'(o_biu_cmd_wmask == '0), field(issue_idx, C_WMZ), "BIU wmask zero");
      check_val(32'(o_biu_cmd_read), field(issue_idx, C_READ), "BIU read");
      check_val(o_biu_cmd_wdata, field(issue_idx, C_WDATA), "BIU write data");
      check_val(32'(o_biu_cmd_size), field(issue_idx, C_SIZE), "BIU size");
      check_val(32'(o_biu_cmd_excl), field(issue_idx, C_EXCL), "BIU exclusive");
      check_val(32'(o_biu_cmd_lock), field(issue_idx, C_EXCL), "BIU lock");
      if (bq.size() == 0) bd = rand_delay();
      bq.push_back(issue_idx);
    end
    issue_idx++;
    trap_sent = 1'b0;
  endtask

  task automatic check_rsp(input int i);
    int err_before;
    err_before = errors;
    w = field(i, C_B2A);
    if (w[0]) begin
      check_val(32'(o_agu_rsp_valid), 32'd1, "AGU response valid");
      check_val(32'(o_lsu_o_valid), 32'd0, "write-back valid on back2agu");
      check_val(o_agu_rsp_rdata, field(i, C_WB), "AGU response data");
      check_val(32'(o_agu_rsp_err), field(i, C_ERR), "AGU response error");
      check_val(32'(o_agu_rsp_excl_ok), 32'(i % 2), "AGU response exclusive ok");
    end else begin
      check_val(32'(o_lsu_o_valid), 32'd1, "write-back valid");
      check_val(32'(o_agu_rsp_valid), 32'd0, "AGU response valid on write-back");
      check_val(o_lsu_o_wbck_wdat, field(i, C_WB), "write-back data");
      check_val(32'(o_lsu_o_wbck_itag), field(i, C_ITAG), "write-back tag");
      check_val(32'(o_lsu_o_wbck_err), field(i, C_ERR), "write-back error");
      check_val(32'(o_lsu_o_cmt_buserr), field(i, C_ERR), "bus error");
      check_val(32'(o_lsu_o_cmt_ld), field(i, C_READ), "commit load");
      check_val(32'(o_lsu_o_cmt_st), 32'(field(i, C_READ) == 32'd0), "commit store");
      w = field(i, C_ERR);
      if (w[0]) check_val(o_lsu_o_cmt_badaddr, field(i, C_ADDR), "bad address");
    end
    test_err = errors - err_before;
    if (test_err == 0) $display("Test %0d tag %0d: ok", i, field(i, C_ITAG));
    else $display("Test %0d tag %0d: %0d errors", i, field(i, C_ITAG), test_err);
    done_cnt++;
  endtask

  initial begin
    clk = 1'b0;
    i_arst_n = 1'b0;
    i_commit_trap = 1'b0;
    i_commit_mret = 1'b0;
    i_dtcm_region_indic = 32'h8000_0000;
    i_agu_cmd_valid = 1'b0;
    $readmemh("lsu_ctrl_patterns.txt", pat);
    n_pat = int'(pat[0]);
    drive_cmd(0);
    i_agu_cmd_wmask = 4'hf;
    i_agu_rsp_ready = 1'b1;
    i_lsu_o_ready = 1'b1;
    i_dtcm_cmd_ready = 1'b1;
    i_biu_cmd_ready = 1'b1;
    i_dtcm_rsp_valid = 1'b0;
    i_dtcm_rsp_err = 1'b0;
    i_dtcm_rsp_excl_ok = 1'b0;
    i_dtcm_rsp_rdata = '0;
    i_biu_rsp_valid = 1'b0;
    i_biu_rsp_err = 1'b0;
    i_biu_rsp_excl_ok = 1'b0;
    i_biu_rsp_rdata = '0;
    rnd_state = 32'd57783;
    {errors, checks, issue_idx, done_cnt, idle, dd, bd} = '0;
    {dp, bp, trap_sent, hold_valid, timed_out} = '0;
    for (int c = 0; c < 16; c++) @(negedge clk);
    i_arst_n = 1'b1;
    @(negedge clk);
    while (done_cnt < n_pat && !timed_out) begin
      @(negedge clk);
      rnd_state = xorshift32(rnd_state);
      i_dtcm_cmd_ready = (rnd_state[1:0] != 2'b00);
      i_biu_cmd_ready  = (rnd_state[3:2] != 2'b00);
      i_lsu_o_ready    = (rnd_state[5:4] != 2'b00);
      i_agu_rsp_ready  = (rnd_state[7:6] != 2'b00);
      drive_targets();
      i_commit_trap   = 1'b0;
      i_agu_cmd_valid = 1'b0;
      if (issue_idx < n_pat) begin
        drive_cmd(issue_idx);
        w = field(issue_idx, C_TRAP);
        // A trap waits for the pipe to drain, then issue resumes
        if (w[0] && !trap_sent) begin
          if (done_cnt == issue_idx) begin
            i_commit_trap = 1'b1;
            trap_sent = 1'b1;
          end
        end else begin
          i_agu_cmd_valid = 1'b1;
        end
      end
      #1;
      idle++;
      if (hold_valid) begin
        check_val(32'(o_agu_rsp_valid), 32'd1, "AGU response held");
        check_val(o_agu_rsp_rdata, hold_data, "AGU response data held");
      end
      hold_valid = o_agu_rsp_valid & ~i_agu_rsp_ready;
      hold_data  = o_agu_rsp_rdata;
      if (i_agu_cmd_valid && o_agu_cmd_ready) begin
        check_cmd();
        idle = 0;
      end
      if ((dp && o_dtcm_rsp_ready) || (bp && o_biu_rsp_ready)) begin
        idx = (dp && o_dtcm_rsp_ready) ? dq.pop_front() : bq.pop_front();
        check_val(32'(idx), 32'(done_cnt), "response order");
        check_rsp(done_cnt);
        if (dp && o_dtcm_rsp_ready) begin
          dp = 1'b0;
          dd = rand_delay();
        end else begin
          bp = 1'b0;
          bd = rand_delay();
        end
        idle = 0;
      end
      if (idle > IDLE_LIMIT) timed_out = 1'b1;
    end
    if (timed_out) begin
      $display("Timeout: no transfer for %0d cycles, %0d of %0d tests done",
               IDLE_LIMIT, done_cnt, n_pat);
    end
    $display("Tests %0d, checks %0d, errors %0d", done_cnt, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
